//--- exec_pipeline.f
verilog/exec_pkg.sv
verilog/issue_queue.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/execution_registers.sv
verilog/memory_stage.sv
verilog/exec_pipeline.sv
verification/exec_pipeline_tb.sv

//--- verification/exec_pipeline_tb.sv
/*
  Directed testbench for the execute, memory and writeback back end.
  A reference model predicts every retire in issue order while the bench
  plays both the credit-limited issuer and the retire consumer.
*/
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline_tb;

  import exec_pkg::*;

  logic      clk;
  logic      rst_n;
  logic      issue_valid;
  issue_op_t issue_op;
  logic      sink_credit;
  logic      issue_credit;
  retire_t   retire;

  // Reference state and expected retires in program order
  logic [WORD_WIDTH-1:0] model_regs [2**REG_INDEX_WIDTH];
  logic [WORD_WIDTH-1:0] model_mem [2**MEM_INDEX_WIDTH];
  retire_t               expected_q [$];

  // Issuer credits and running totals
  int credits;
  int issued;
  int retired;
  int credit_pulses;
  int error_count;

  logic [31:0] rand_state = 32'd29977;

  exec_pipeline UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .sink_credit  (sink_credit),
    .issue_credit (issue_credit),
    .retire       (retire)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // LCG for operands and immediates
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  // Register index taken from upper LCG bits
  function automatic logic [2:0] rand_reg();
    logic [31:0] r;
    r = next_rand();
    return r[18:16];
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("[ERROR] %0t: %s: got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Reference model of one op applied at issue time in program order
  function automatic void predict(input issue_op_t op);
    logic [WORD_WIDTH-1:0]      a;
    logic [WORD_WIDTH-1:0]      b;
    logic [WORD_WIDTH-1:0]      sum;
    logic [MEM_INDEX_WIDTH-1:0] addr;
    retire_t                    expected;
    a = model_regs[op.rs1];
    b = model_regs[op.rs2];
    sum = a + op.imm;
    addr = sum[MEM_INDEX_WIDTH-1:0];
    expected.valid = 1'b1;
    expected.reg_write = 1'b1;
    expected.rd = op.rd;
    case (op.op)
      OP_ADD:  expected.data = a + b;
      OP_SUB:  expected.data = a - b;
      OP_AND:  expected.data = a & b;
      OP_OR:   expected.data = a | b;
      OP_XOR:  expected.data = a ^ b;
      OP_SLT:  expected.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_ADDI: expected.data = sum;
      OP_LOAD: expected.data = model_mem[addr];
      OP_STORE:
      begin
        // Store retires its address sum and writes no register
        expected.data = sum;
        expected.reg_write = 1'b0;
        model_mem[addr] = b;
      end
      default: expected.data = '0;
    endcase
    if (expected.reg_write && (op.rd != '0))
    begin
      model_regs[op.rd] = expected.data;
    end
    expected_q.push_back(expected);
  endfunction

  // Issue one op once a credit is held and drive it for a single cycle
  task automatic send_op(input opcode_t opc, input logic [2:0] rd, input logic [2:0] rs1,
                         input logic [2:0] rs2, input logic [31:0] imm);
    issue_op_t op;
    op.op = opc;
    op.rd = rd;
    op.rs1 = rs1;
    op.rs2 = rs2;
    op.imm = imm;
    while (credits == 0)
      @(negedge clk);
    issue_valid = 1'b1;
    issue_op = op;
    credits--;
    issued++;
    predict(op);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expected_q.size() != 0)
      @(negedge clk);
    @(negedge clk);
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    issue_valid = 1'b0;
    sink_credit = 1'b0;
    repeat (10) @(negedge clk);
    foreach (model_regs[i])
      model_regs[i] = '0;
    foreach (model_mem[i])
      model_mem[i] = '0;
    credits = QUEUE_DEPTH;
    rst_n = 1'b1;
    @(negedge clk);
  endtask

  // Outputs change only at posedge, so the falling edge sees them settled
  always @(negedge clk)
  begin : retire_monitor
    retire_t expected;
    if (issue_credit === 1'b1)
    begin
      credit_pulses++;
      credits++;
    end
    if (retire.valid === 1'b1)
    begin
      if (expected_q.size() == 0)
      begin
        $display("A retire appeared at %0t with no operation outstanding", $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "Unexpected retire");
      end
      expected = expected_q.pop_front();
      check_value("retire reg_write", retire.reg_write, expected.reg_write);
      check_value("retire rd", retire.rd, expected.rd);
      check_value("retire data", retire.data, expected.data);
      retired++;
    end
  end

  // Budget grows with every issued op
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    forever
    begin
      @(posedge clk);
      cycles++;
      if (cycles > 20 * issued + 200)
      begin
        $display("Run timed out before all retires appeared");
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
      end
    end
  end

  task automatic test_reset_state();
    repeat (5)
    begin
      check_value("retire.valid after reset", retire.valid, 1'b0);
      check_value("issue_credit after reset", issue_credit, 1'b0);
      @(negedge clk);
    end
    send_op(OP_ADD, 3'd1, 3'd0, 3'd0, 32'd0);
    // Head launches in the cycle after the issue edge
    check_value("issue_credit in launch cycle", issue_credit, 1'b1);
    @(negedge clk);
    check_value("retire.valid one cycle after launch", retire.valid, 1'b0);
    @(negedge clk);
    check_value("retire.valid two cycles after launch", retire.valid, 1'b1);
    wait_drain();
  endtask

  task automatic test_alu_ops();
    opcode_t alu_ops [6];
    alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
    // Consumer always ready from here on
    sink_credit = 1'b1;
    for (int i = 1; i < 8; i++)
      send_op(OP_ADDI, 3'(i), 3'd0, 3'd0, next_rand());
    wait_drain();
    for (int round = 0; round < 2; round++)
    begin
      foreach (alu_ops[i])
      begin
        send_op(alu_ops[i], rand_reg(), rand_reg(), rand_reg(), 32'd0);
        repeat (4) @(negedge clk);
      end
    end
    wait_drain();
  endtask

  task automatic test_forwarding();
    // Distance 1 where each op reads the one right before it
    send_op(OP_ADDI, 3'd1, 3'd0, 3'd0, next_rand());
    send_op(OP_ADD, 3'd2, 3'd1, 3'd1, 32'd0);
    send_op(OP_SUB, 3'd3, 3'd2, 3'd1, 32'd0);
    // Distance 2 with independent fillers between
    send_op(OP_ADDI, 3'd4, 3'd0, 3'd0, next_rand());
    send_op(OP_ADDI, 3'd7, 3'd0, 3'd0, next_rand());
    send_op(OP_ADD, 3'd5, 3'd4, 3'd4, 32'd0);
    send_op(OP_XOR, 3'd7, 3'd7, 3'd3, 32'd0);
    send_op(OP_SUB, 3'd6, 3'd5, 3'd4, 32'd0);
    // x0 result must never be forwarded
    send_op(OP_ADDI, 3'd0, 3'd0, 3'd0, next_rand());
    send_op(OP_ADD, 3'd1, 3'd0, 3'd0, 32'd0);
    wait_drain();
  endtask

  task automatic test_load_store();
    logic [31:0] addrs [4];
    foreach (addrs[i])
    begin
      addrs[i] = next_rand();
      send_op(OP_STORE, 3'd0, 3'd0, 3'(i + 2), addrs[i]);
    end
    foreach (addrs[i])
      send_op(OP_LOAD, 3'(i + 4), 3'd0, 3'd0, addrs[i]);
    // Load-use back to back
    send_op(OP_LOAD, 3'd2, 3'd0, 3'd0, addrs[1]);
    send_op(OP_ADD, 3'd3, 3'd2, 3'd1, 32'd0);
    wait_drain();
  endtask

  task automatic test_retire_credits();
    int pulses_before;
    int retired_before;
    // Fresh reset puts the retire credits back at two
    reset_dut();
    send_op(OP_ADDI, 3'd1, 3'd0, 3'd0, next_rand());
    send_op(OP_ADDI, 3'd2, 3'd0, 3'd0, next_rand());
    wait_drain();
    for (int i = 0; i < QUEUE_DEPTH; i++)
      send_op(OP_ADD, rand_reg(), 3'd1, 3'd2, 32'd0);
    check_value("issuer credits with full queue", credits, 0);
    pulses_before = credit_pulses;
    retired_before = retired;
    repeat (20) @(negedge clk);
    check_value("retires without retire credits", retired, retired_before);
    check_value("issue credits without launches", credit_pulses, pulses_before);
    for (int i = 0; i < QUEUE_DEPTH; i++)
    begin
      retired_before = retired;
      sink_credit = 1'b1;
      @(negedge clk);
      sink_credit = 1'b0;
      repeat (6) @(negedge clk);
      check_value("retires per sink credit", retired, retired_before + 1);
    end
    wait_drain();
  endtask

  task automatic test_issue_credits();
    int pulses_before;
    pulses_before = credit_pulses;
    sink_credit = 1'b1;
    for (int i = 0; i < 12; i++)
    begin
      if (i % 2 == 0)
        send_op(OP_ADDI, rand_reg(), rand_reg(), 3'd0, next_rand());
      else
        send_op(OP_ADD, rand_reg(), rand_reg(), rand_reg(), 32'd0);
    end
    wait_drain();
    check_value("issue credit pulses", credit_pulses - pulses_before, 12);
    check_value("issuer credits after drain", credits, QUEUE_DEPTH);
    sink_credit = 1'b0;
  endtask

  initial
  begin
    rst_n = 1'b0;
    issue_valid = 1'b0;
    issue_op = '0;
    sink_credit = 1'b0;
    issued = 0;
    retired = 0;
    credit_pulses = 0;
    error_count = 0;
    reset_dut();
    test_reset_state();
    test_alu_ops();
    test_forwarding();
    test_load_store();
    test_retire_credits();
    test_issue_credits();
    if (error_count == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/exec_pipeline.sv
/*
  Top of the three-stage back end. Ops enter through the credit-controlled
  issue queue and leave on the retire port two cycles after launch.
*/
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue_valid,
  input  exec_pkg::issue_op_t issue_op,
  input  logic                sink_credit,
  output logic                issue_credit,
  output exec_pkg::retire_t   retire
);

  import exec_pkg::*;

  issue_op_t                  head;
  logic                       head_valid;
  logic                       pop;
  logic [REG_INDEX_WIDTH-1:0] rs1_index;
  logic [REG_INDEX_WIDTH-1:0] rs2_index;
  logic [WORD_WIDTH-1:0]      rs1_data;
  logic [WORD_WIDTH-1:0]      rs2_data;
  ex_mem_t                    ex_next;
  ex_mem_t                    ex_mem;
  retire_t                    mem_result;

  issue_queue u_issue_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (issue_valid),
    .push_op      (issue_op),
    .pop          (pop),
    .head         (head),
    .head_valid   (head_valid),
    .issue_credit (issue_credit)
  );

  // Register file sits beside execute, written from the writeback register
  register_file u_register_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_index  (rs1_index),
    .rs2_index  (rs2_index),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .write_port (retire)
  );

  execute_stage u_execute_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .head        (head),
    .head_valid  (head_valid),
    .sink_credit (sink_credit),
    .pop         (pop),
    .rs1_index   (rs1_index),
    .rs2_index   (rs2_index),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .mem_result  (mem_result),
    .wb          (retire),
    .ex_next     (ex_next)
  );

  execution_registers u_execution_registers (
    .clk     (clk),
    .rst_n   (rst_n),
    .ex_next (ex_next),
    .ex_mem  (ex_mem)
  );

  // Writeback register drives the retire port directly
  memory_stage u_memory_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_mem     (ex_mem),
    .mem_result (mem_result),
    .wb         (retire)
  );

endmodule

`default_nettype wire

//--- verilog/exec_pkg.sv
/*
  Shared widths, opcode encoding and stage payload structs for the
  execute, memory and writeback back end. Every RTL module imports it.
*/
`default_nettype none

package exec_pkg;

  // Datapath and storage sizes
  localparam int WORD_WIDTH = 32;
  localparam int REG_INDEX_WIDTH = 3;
  localparam int MEM_INDEX_WIDTH = 4;

  // Issue queue size, also the issuer's credits after reset
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

  // Retire slots owned after reset, and counter width for both credit kinds
  localparam int RETIRE_CREDITS = 2;
  localparam int CREDIT_WIDTH = 3;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLT   = 4'd5,  // signed compare
    OP_ADDI  = 4'd6,
    OP_LOAD  = 4'd7,
    OP_STORE = 4'd8
  } opcode_t;

  // Decoded operation as it arrives on the issue port and sits in the queue
  typedef struct packed {
    opcode_t                    op;
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [REG_INDEX_WIDTH-1:0] rs1;
    logic [REG_INDEX_WIDTH-1:0] rs2;
    logic [WORD_WIDTH-1:0]      imm;
  } issue_op_t;

  // Contents of the execute to memory register
  typedef struct packed {
    logic                       valid;
    logic                       mem_read;
    logic                       mem_write;
    logic                       reg_write;
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [WORD_WIDTH-1:0]      alu_result;
    logic [WORD_WIDTH-1:0]      store_data;
  } ex_mem_t;

  // Result of a finished op, used for writeback, retire and forwarding
  typedef struct packed {
    logic                       valid;
    logic                       reg_write;
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [WORD_WIDTH-1:0]      data;
  } retire_t;

endpackage

`default_nettype wire

//--- verilog/execute_stage.sv
/*
  Execute stage: retire-credit tracking, launch of the queue head,
  operand forwarding from memory and writeback, and the ALU.
*/
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  exec_pkg::issue_op_t                  head,
  input  logic                                 head_valid,
  input  logic                                 sink_credit,
  output logic                                 pop,
  output logic [exec_pkg::REG_INDEX_WIDTH-1:0] rs1_index,
  output logic [exec_pkg::REG_INDEX_WIDTH-1:0] rs2_index,
  input  logic [exec_pkg::WORD_WIDTH-1:0]      rs1_data,
  input  logic [exec_pkg::WORD_WIDTH-1:0]      rs2_data,
  input  exec_pkg::retire_t                    mem_result,
  input  exec_pkg::retire_t                    wb,
  output exec_pkg::ex_mem_t                    ex_next
);

  import exec_pkg::*;

  logic [CREDIT_WIDTH-1:0] retire_credits;
  logic                    credits_full;
  logic [WORD_WIDTH-1:0]   operand_a;
  logic [WORD_WIDTH-1:0]   operand_b;
  logic [WORD_WIDTH-1:0]   alu_result;

  // Launch only when the consumer has room for the result
  assign pop          = head_valid && (retire_credits != '0);
  assign credits_full = &retire_credits;

  // Launch and grant in the same cycle cancel out
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      retire_credits <= CREDIT_WIDTH'(RETIRE_CREDITS);
    end
    else if (sink_credit && !pop && !credits_full)
    begin
      retire_credits <= retire_credits + 1'b1;  // saturate rather than wrap
    end
    else if (pop && !sink_credit)
    begin
      retire_credits <= retire_credits - 1'b1;
    end
  end

  assign rs1_index = head.rs1;
  assign rs2_index = head.rs2;

  // Newest producer first: memory stage, then writeback, then the register file
  always_comb
  begin
    operand_a = rs1_data;
    if (mem_result.valid && mem_result.reg_write && (mem_result.rd != '0)
        && (mem_result.rd == head.rs1))
    begin
      operand_a = mem_result.data;
    end
    else if (wb.valid && wb.reg_write && (wb.rd != '0) && (wb.rd == head.rs1))
    begin
      operand_a = wb.data;
    end

    operand_b = rs2_data;
    if (mem_result.valid && mem_result.reg_write && (mem_result.rd != '0)
        && (mem_result.rd == head.rs2))
    begin
      operand_b = mem_result.data;
    end
    else if (wb.valid && wb.reg_write && (wb.rd != '0) && (wb.rd == head.rs2))
    begin
      operand_b = wb.data;
    end
  end

  always_comb
  begin
    case (head.op)
      OP_ADD:   alu_result = operand_a + operand_b;
      OP_SUB:   alu_result = operand_a - operand_b;
      OP_AND:   alu_result = operand_a & operand_b;
      OP_OR:    alu_result = operand_a | operand_b;
      OP_XOR:   alu_result = operand_a ^ operand_b;
      OP_SLT:   alu_result = {{(WORD_WIDTH-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      // Immediate forms, also the load/store address
      OP_ADDI,
      OP_LOAD,
      OP_STORE: alu_result = operand_a + head.imm;
      default:  alu_result = '0;
    endcase
  end

  // Stores carry rs2 down to memory and write no register
  assign ex_next.valid      = pop;
  assign ex_next.mem_read   = (head.op == OP_LOAD);
  assign ex_next.mem_write  = (head.op == OP_STORE);
  assign ex_next.reg_write  = (head.op != OP_STORE);
  assign ex_next.rd         = head.rd;
  assign ex_next.alu_result = alu_result;
  assign ex_next.store_data = operand_b;

endmodule

`default_nettype wire

//--- verilog/execution_registers.sv
/*
  Stage register between execute and memory. The payload loads only for
  a launched op; the valid bit tracks its input on every edge.
*/
`timescale 1ns/1ps
`default_nettype none

module execution_registers (
  input  logic              clk,
  input  logic              rst_n,
  input  exec_pkg::ex_mem_t ex_next,
  output exec_pkg::ex_mem_t ex_mem
);

  import exec_pkg::*;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_mem <= '0;
    end
    else if (ex_next.valid)
    begin
      // Whole op moves forward
      ex_mem <= ex_next;
    end
    else
    begin
      // Bubble, old fields stay but are marked stale
      ex_mem.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/issue_queue.sv
/*
  Four-entry FIFO between the external issuer and the execute stage.
  Each pop hands one issue credit back to the issuer.
*/
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  exec_pkg::issue_op_t push_op,
  input  logic                pop,
  output exec_pkg::issue_op_t head,
  output logic                head_valid,
  output logic                issue_credit
);

  import exec_pkg::*;

  // Entry storage for queued ops
  issue_op_t entries [QUEUE_DEPTH];

  logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
  logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
  logic [CREDIT_WIDTH-1:0]    count;
  logic                       pop_accepted;

  // Oldest entry is always at the read pointer
  assign head         = entries[rd_ptr];
  assign head_valid   = (count != '0);
  assign pop_accepted = pop && head_valid;

  // Credit goes back in the same cycle the entry leaves
  assign issue_credit = pop_accepted;

  // The issuer never pushes without a credit, so a push never meets a full queue
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      entries[wr_ptr] <= push_op;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap naturally at the power-of-two depth
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_accepted)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop_accepted)
      begin
        count <= count + 1'b1;
      end
      else if (!push && pop_accepted)
      begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
/*
  Memory stage with a 16-word data memory. Forms the stage result from the
  ALU value or load data, and registers it as writeback and retire.
*/
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  exec_pkg::ex_mem_t ex_mem,
  output exec_pkg::retire_t mem_result,
  output exec_pkg::retire_t wb
);

  import exec_pkg::*;

  logic [WORD_WIDTH-1:0]      mem [2**MEM_INDEX_WIDTH];
  logic [MEM_INDEX_WIDTH-1:0] word_index;
  logic                       store_en;

  // Word address is the low bits of rs1 + imm
  assign word_index = ex_mem.alu_result[MEM_INDEX_WIDTH-1:0];
  assign store_en   = ex_mem.valid && ex_mem.mem_write;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2**MEM_INDEX_WIDTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (store_en)
    begin
      mem[word_index] <= ex_mem.store_data;
    end
  end

  // Combinational result, also the newest forwarding source for execute
  assign mem_result.valid     = ex_mem.valid;
  assign mem_result.reg_write = ex_mem.reg_write;
  assign mem_result.rd        = ex_mem.rd;
  assign mem_result.data      = ex_mem.mem_read ? mem[word_index] : ex_mem.alu_result;

  // Writeback register, valid for exactly one cycle per op
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb <= '0;
    end
    else
    begin
      wb <= mem_result;
    end
  end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
/*
  Eight 32-bit integer registers with two combinational read ports.
  Written from the writeback register; x0 always reads zero.
*/
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [exec_pkg::REG_INDEX_WIDTH-1:0] rs1_index,
  input  logic [exec_pkg::REG_INDEX_WIDTH-1:0] rs2_index,
  output logic [exec_pkg::WORD_WIDTH-1:0]      rs1_data,
  output logic [exec_pkg::WORD_WIDTH-1:0]      rs2_data,
  input  exec_pkg::retire_t                    write_port
);

  import exec_pkg::*;

  logic [WORD_WIDTH-1:0] regs [2**REG_INDEX_WIDTH];
  logic                  write_en;

  // x0 is never written
  assign write_en = write_port.valid && write_port.reg_write && (write_port.rd != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2**REG_INDEX_WIDTH; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (write_en)
    begin
      regs[write_port.rd] <= write_port.data;
    end
  end

  // Same-cycle writes are not bypassed here, execute forwards from wb instead
  assign rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
  assign rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire
